// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // Width of the program counter, the address and the store data
   // The byte select width is derived from it as OPERAND_WIDTH/8
   localparam int OPERAND_WIDTH = 32;

   // Store buffer pointer width
   // 2**SB_DEPTH_WIDTH slots, one of them is always kept free
   // so full and empty can be told apart from the pointers alone
   localparam int SB_DEPTH_WIDTH = 3;

   // States of the APB drain unit
   // IDLE    waiting for the buffer to hold an entry
   // POP     read was issued, popped entry appears on the buffer outputs
   // SETUP   APB setup phase, psel high and penable low
   // ACCESS  APB access phase, held until the slave returns pready
   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      POP    = 2'd1,
      SETUP  = 2'd2,
      ACCESS = 2'd3
   } drain_state_e;

endpackage : lsu_pkg

`default_nettype wire

// ==== src/sb_rd_if.sv ====
`default_nettype none

// Read side of the store buffer, shared by the buffer and the drain unit
interface sb_rd_if #(
   parameter int OPERAND_WIDTH = lsu_pkg::OPERAND_WIDTH
);

   // Pop request, only legal while empty is low
   logic                       read;
   logic                       empty;

   // Popped entry, valid one cycle after read and held until the next read
   logic [OPERAND_WIDTH-1:0]   pc;
   logic [OPERAND_WIDTH-1:0]   adr;
   logic [OPERAND_WIDTH-1:0]   dat;
   logic [OPERAND_WIDTH/8-1:0] bsel;

   modport buffer (input read, output empty, output pc, output adr, output dat, output bsel);

   modport drain (output read, input empty, input pc, input adr, input dat, input bsel);

endinterface : sb_rd_if

`default_nettype wire

// ==== src/sb_dpram.sv ====
`default_nettype none

module sb_dpram #(
   parameter int ADDR_WIDTH = 3,
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  we_i,
   input  logic [ADDR_WIDTH-1:0] waddr_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   input  logic [ADDR_WIDTH-1:0] raddr_i,
   output logic [DATA_WIDTH-1:0] dout_o
);

   // Storage array
   logic [DATA_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1];

   // Registered read data from the array
   logic [DATA_WIDTH-1:0] rdata_q;

   // Bypass path for a write and a read to the same word
   logic                  bypass_q;
   logic [DATA_WIDTH-1:0] din_q;

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Synchronous read port, old contents on a collision
   always_ff @(posedge clk) begin
      rdata_q <= mem[raddr_i];
   end

   // Remember a same-address write so the new word wins
   always_ff @(posedge clk) begin
      bypass_q <= we_i && (waddr_i == raddr_i);
      din_q    <= din_i;
   end

   assign dout_o = bypass_q ? din_q : rdata_q;

endmodule : sb_dpram

`default_nettype wire

// ==== src/store_buffer.sv ====
`default_nettype none

module store_buffer #(
   parameter int DEPTH_WIDTH   = 3,
   parameter int OPERAND_WIDTH = 32
) (
   input  logic                       clk,
   input  logic                       rst,

   // Core side
   input  logic                       write_i,
   input  logic [OPERAND_WIDTH-1:0]   pc_i,
   input  logic [OPERAND_WIDTH-1:0]   adr_i,
   input  logic [OPERAND_WIDTH-1:0]   dat_i,
   input  logic [OPERAND_WIDTH/8-1:0] bsel_i,
   output logic                       full_o,

   // Drain side
   sb_rd_if.buffer                    rd
);

   // One RAM word holds address, data, byte selects and pc
   localparam int ENTRY_WIDTH = OPERAND_WIDTH*3 + OPERAND_WIDTH/8;

   logic [ENTRY_WIDTH-1:0] entry_din;
   logic [ENTRY_WIDTH-1:0] ram_dout;
   // Held copy of the last popped entry
   logic [ENTRY_WIDTH-1:0] entry_q;
   logic [ENTRY_WIDTH-1:0] entry_out;

   logic [DEPTH_WIDTH-1:0] wr_ptr_q;
   logic [DEPTH_WIDTH-1:0] rd_ptr_q;
   logic [DEPTH_WIDTH-1:0] prev_rd_ptr;

   // Pop on the last edge means the RAM output is the fresh entry
   logic                   read_q;
   logic                   wr_en;

   assign entry_din = {adr_i, dat_i, bsel_i, pc_i};

   // One slot stays unused when full so the pointers tell full from empty
   assign prev_rd_ptr = rd_ptr_q - 1'b1;
   assign full_o      = (wr_ptr_q == prev_rd_ptr);
   assign rd.empty    = (wr_ptr_q == rd_ptr_q);

   // Stores arriving while full are dropped
   assign wr_en = write_i && !full_o;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr_q <= '0;
      end else if (wr_en) begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr_q <= '0;
      end else if (rd.read) begin
         rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         read_q <= 1'b0;
      end else begin
         read_q <= rd.read;
      end
   end

   // Capture the popped word so it survives later RAM reads
   always_ff @(posedge clk) begin
      if (read_q) begin
         entry_q <= ram_dout;
      end
   end

   // RAM output right after a pop and the held copy otherwise
   assign entry_out = read_q ? ram_dout : entry_q;
   assign {rd.adr, rd.dat, rd.bsel, rd.pc} = entry_out;

   // RAM always reads at the read pointer
   sb_dpram #(
      .ADDR_WIDTH (DEPTH_WIDTH),
      .DATA_WIDTH (ENTRY_WIDTH)
   ) u_ram (
      .clk     (clk),
      .we_i    (wr_en),
      .waddr_i (wr_ptr_q),
      .din_i   (entry_din),
      .raddr_i (rd_ptr_q),
      .dout_o  (ram_dout)
   );

   // Drain unit must never pop an empty buffer
   assert property (@(posedge clk) disable iff (rst) rd.read |-> !rd.empty)
      else $error("store_buffer: read while empty");

   // A reset cycle leaves both pointers at zero whatever write and read do
   assert property (@(posedge clk) $past(rst) |-> ((wr_ptr_q == '0) && (rd_ptr_q == '0)))
      else $error("store_buffer: pointer moved during reset");

endmodule : store_buffer

`default_nettype wire

// ==== src/sb_drain_apb.sv ====
`default_nettype none

module sb_drain_apb #(
   parameter int OPERAND_WIDTH = 32
) (
   input  logic                       clk,
   input  logic                       rst,

   // Buffer read side
   sb_rd_if.drain                     rd,

   // APB master
   output logic [OPERAND_WIDTH-1:0]   paddr_o,
   output logic                       psel_o,
   output logic                       penable_o,
   output logic                       pwrite_o,
   output logic [OPERAND_WIDTH-1:0]   pwdata_o,
   output logic [OPERAND_WIDTH/8-1:0] pstrb_o,
   input  logic                       pready_i,
   input  logic                       pslverr_i,

   // Bus error report towards the core
   output logic                       err_o,
   output logic [OPERAND_WIDTH-1:0]   err_pc_o
);

   import lsu_pkg::*;

   drain_state_e state_q;
   drain_state_e state_d;

   // Registered transfer, loaded while in POP
   logic [OPERAND_WIDTH-1:0]   paddr_q;
   logic [OPERAND_WIDTH-1:0]   pwdata_q;
   logic [OPERAND_WIDTH/8-1:0] pstrb_q;
   // pc of the store in flight, kept for error reporting
   logic [OPERAND_WIDTH-1:0]   pc_q;

   logic                       err_q;
   logic [OPERAND_WIDTH-1:0]   err_pc_q;

   // Last cycle of the access phase
   logic                       xfer_done;

   // Pop as soon as the buffer holds something
   assign rd.read = (state_q == IDLE) && !rd.empty;

   assign xfer_done = (state_q == ACCESS) && pready_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (!rd.empty) begin
               state_d = POP;
            end
         end
         // Entry shows up on the buffer outputs here
         POP:    state_d = SETUP;
         SETUP:  state_d = ACCESS;
         ACCESS: begin
            // Wait states until the slave is ready
            if (pready_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Latch the popped entry for the whole transfer
   always_ff @(posedge clk) begin
      if (state_q == POP) begin
         paddr_q  <= rd.adr;
         pwdata_q <= rd.dat;
         pstrb_q  <= rd.bsel;
         pc_q     <= rd.pc;
      end
   end

   // One-cycle error pulse after a failed transfer
   always_ff @(posedge clk) begin
      if (rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= xfer_done && pslverr_i;
      end
   end

   always_ff @(posedge clk) begin
      if (xfer_done && pslverr_i) begin
         err_pc_q <= pc_q;
      end
   end

   // Bus controls decoded from the state register
   assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
   assign penable_o = (state_q == ACCESS);
   // Only writes leave this unit
   assign pwrite_o  = psel_o;
   assign paddr_o   = paddr_q;
   assign pwdata_o  = pwdata_q;
   assign pstrb_o   = pstrb_q;
   assign err_o     = err_q;
   assign err_pc_o  = err_pc_q;

   // Transfer payload holds until the completing edge
   assert property (@(posedge clk) disable iff (rst)
      (psel_o && !(penable_o && pready_i)) |=>
         ($stable(paddr_o) && $stable(pwdata_o) && $stable(pstrb_o) && $stable(pwrite_o)))
      else $error("sb_drain_apb: APB payload changed during transfer");

   // Access phase only ever follows a setup cycle
   assert property (@(posedge clk) disable iff (rst)
      $rose(penable_o) |-> $past(psel_o && !penable_o))
      else $error("sb_drain_apb: penable without setup phase");

endmodule : sb_drain_apb

`default_nettype wire

// ==== src/sb_top.sv ====
`default_nettype none

module sb_top #(
   parameter int DEPTH_WIDTH   = lsu_pkg::SB_DEPTH_WIDTH,
   parameter int OPERAND_WIDTH = lsu_pkg::OPERAND_WIDTH
) (
   input  logic                       clk,
   input  logic                       rst,

   // Stores from the core
   input  logic                       write_i,
   input  logic [OPERAND_WIDTH-1:0]   pc_i,
   input  logic [OPERAND_WIDTH-1:0]   adr_i,
   input  logic [OPERAND_WIDTH-1:0]   dat_i,
   input  logic [OPERAND_WIDTH/8-1:0] bsel_i,
   output logic                       full_o,
   output logic                       empty_o,

   // APB master
   output logic [OPERAND_WIDTH-1:0]   paddr_o,
   output logic                       psel_o,
   output logic                       penable_o,
   output logic                       pwrite_o,
   output logic [OPERAND_WIDTH-1:0]   pwdata_o,
   output logic [OPERAND_WIDTH/8-1:0] pstrb_o,
   input  logic                       pready_i,
   input  logic                       pslverr_i,

   // Precise bus error report
   output logic                       err_o,
   output logic [OPERAND_WIDTH-1:0]   err_pc_o
);

   // Buffer to drain link
   sb_rd_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_rd_if ();

   store_buffer #(
      .DEPTH_WIDTH   (DEPTH_WIDTH),
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) u_store_buffer (
      .clk     (clk),
      .rst     (rst),
      .write_i (write_i),
      .pc_i    (pc_i),
      .adr_i   (adr_i),
      .dat_i   (dat_i),
      .bsel_i  (bsel_i),
      .full_o  (full_o),
      .rd      (u_rd_if.buffer)
   );

   sb_drain_apb #(
      .OPERAND_WIDTH (OPERAND_WIDTH)
   ) u_drain (
      .clk       (clk),
      .rst       (rst),
      .rd        (u_rd_if.drain),
      .paddr_o   (paddr_o),
      .psel_o    (psel_o),
      .penable_o (penable_o),
      .pwrite_o  (pwrite_o),
      .pwdata_o  (pwdata_o),
      .pstrb_o   (pstrb_o),
      .pready_i  (pready_i),
      .pslverr_i (pslverr_i),
      .err_o     (err_o),
      .err_pc_o  (err_pc_o)
   );

   // Core sees the buffer's own empty flag
   assign empty_o = u_rd_if.empty;

endmodule : sb_top

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_o
);

   // Free running clock, rising edge at PERIOD/2
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD/2) clk_o = ~clk_o;
   end

   // Synchronous reset, released after RESET_CYCLES rising edges
   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule : tb_clock_gen

`default_nettype wire

// ==== testbench/tb_sb_top.sv ====
`default_nettype none

module tb_sb_top;

   import lsu_pkg::*;

   // All tests together take a few hundred cycles
   localparam int TIMEOUT_CYCLES = 4000;

   logic                       clk;
   logic                       rst;
   logic                       write;
   logic [OPERAND_WIDTH-1:0]   pc;
   logic [OPERAND_WIDTH-1:0]   adr;
   logic [OPERAND_WIDTH-1:0]   dat;
   logic [OPERAND_WIDTH/8-1:0] bsel;
   logic                       full;
   logic                       empty;
   logic [OPERAND_WIDTH-1:0]   paddr;
   logic                       psel;
   logic                       penable;
   logic                       pwrite;
   logic [OPERAND_WIDTH-1:0]   pwdata;
   logic [OPERAND_WIDTH/8-1:0] pstrb;
   logic                       pready = 1'b0;
   logic                       pslverr = 1'b0;
   logic                       err;
   logic [OPERAND_WIDTH-1:0]   err_pc;

   // Stores accepted by the buffer in program order
   logic [OPERAND_WIDTH-1:0]   exp_adr_q [$];
   logic [OPERAND_WIDTH-1:0]   exp_dat_q [$];
   logic [OPERAND_WIDTH/8-1:0] exp_bsel_q [$];
   // Completed APB writes seen by the slave model
   logic [OPERAND_WIDTH-1:0]   got_adr_q [$];
   logic [OPERAND_WIDTH-1:0]   got_dat_q [$];
   logic [OPERAND_WIDTH/8-1:0] got_strb_q [$];
   // One entry per cycle with err_o high
   logic [OPERAND_WIDTH-1:0]   err_pc_q [$];

   int   seed = 32'h54ad_a566;
   int   wait_cnt = 0;
   int   wait_draw;
   int   errors = 0;
   int   checks = 0;
   // Slave controls that only change at falling edges
   bit   hold_ready = 1'b0;
   bit   err_en = 1'b0;
   logic [OPERAND_WIDTH-1:0]   err_adr = '0;

   tb_clock_gen u_clock_gen (.clk_o(clk), .rst_o(rst));

   sb_top u_dut (
      .clk(clk), .rst(rst),
      .write_i(write), .pc_i(pc), .adr_i(adr), .dat_i(dat), .bsel_i(bsel),
      .full_o(full), .empty_o(empty),
      .paddr_o(paddr), .psel_o(psel), .penable_o(penable), .pwrite_o(pwrite),
      .pwdata_o(pwdata), .pstrb_o(pstrb), .pready_i(pready), .pslverr_i(pslverr),
      .err_o(err), .err_pc_o(err_pc)
   );

   task automatic check_word(input string name, input logic [OPERAND_WIDTH-1:0] got,
                             input logic [OPERAND_WIDTH-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_strb(input string name, input logic [OPERAND_WIDTH/8-1:0] got,
                             input logic [OPERAND_WIDTH/8-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // APB slave model with 0 to 3 random wait states
   // pready stays low while hold_ready is set
   always @(posedge clk) begin
      if (rst) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
         wait_cnt <= 0;
      end else if (psel && penable && pready) begin
         got_adr_q.push_back(paddr);
         got_dat_q.push_back(pwdata);
         got_strb_q.push_back(pstrb);
         check_bit("pwrite_o", pwrite, 1'b1);
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else if (psel && !penable) begin
         wait_draw = $random(seed) & 3;
         wait_cnt <= wait_draw;
         pready   <= !hold_ready && (wait_draw == 0);
         pslverr  <= err_en && (paddr == err_adr);
      end else if (psel && penable && !hold_ready) begin
         if (wait_cnt <= 1) begin
            pready <= 1'b1;
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end
   end

   // Error report monitor
   always @(posedge clk) begin
      if (!rst && err) begin
         err_pc_q.push_back(err_pc);
      end
   end

   // Drives one store for a single cycle
   // The buffer takes it when full_o is low at the sampling edge
   task automatic push_store(input logic [OPERAND_WIDTH-1:0] pc_v,
                             input logic [OPERAND_WIDTH-1:0] adr_v,
                             input logic [OPERAND_WIDTH-1:0] dat_v,
                             input logic [OPERAND_WIDTH/8-1:0] bsel_v,
                             input bit ignore_full, output bit accepted);
      @(negedge clk);
      while (full && !ignore_full) @(negedge clk);
      @(posedge clk);
      write <= 1'b1;
      pc    <= pc_v;
      adr   <= adr_v;
      dat   <= dat_v;
      bsel  <= bsel_v;
      @(negedge clk);
      accepted = !full;
      @(posedge clk);
      write <= 1'b0;
      if (accepted) begin
         exp_adr_q.push_back(adr_v);
         exp_dat_q.push_back(dat_v);
         exp_bsel_q.push_back(bsel_v);
      end
   endtask

   // Wait until n writes completed and the bus is idle again
   task automatic wait_drained(input int n);
      @(negedge clk);
      while (got_adr_q.size() < n || psel) @(negedge clk);
      repeat (3) @(negedge clk);
   endtask

   task automatic compare_transfers();
      check_count("transfer count", got_adr_q.size(), exp_adr_q.size());
      while (got_adr_q.size() > 0 && exp_adr_q.size() > 0) begin
         check_word("paddr_o", got_adr_q.pop_front(), exp_adr_q.pop_front());
         check_word("pwdata_o", got_dat_q.pop_front(), exp_dat_q.pop_front());
         check_strb("pstrb_o", got_strb_q.pop_front(), exp_bsel_q.pop_front());
      end
      got_adr_q.delete();
      got_dat_q.delete();
      got_strb_q.delete();
      exp_adr_q.delete();
      exp_dat_q.delete();
      exp_bsel_q.delete();
   endtask

   task automatic test_reset();
      check_bit("psel_o", psel, 1'b0);
      check_bit("penable_o", penable, 1'b0);
      check_bit("err_o", err, 1'b0);
      check_bit("empty_o", empty, 1'b1);
      check_bit("full_o", full, 1'b0);
   endtask

   task automatic test_single_store();
      bit acc;
      push_store(32'h0000_1000, 32'h8000_0010, 32'hcafe_f00d, 4'b0110, 1'b0, acc);
      check_bit("store accepted", acc, 1'b1);
      wait_drained(1);
      compare_transfers();
   endtask

   task automatic test_random_stores();
      bit acc;
      logic [OPERAND_WIDTH-1:0]   r_pc;
      logic [OPERAND_WIDTH-1:0]   r_adr;
      logic [OPERAND_WIDTH-1:0]   r_dat;
      logic [OPERAND_WIDTH/8-1:0] r_bsel;
      for (int i = 0; i < 20; i++) begin
         r_pc   = $random(seed);
         r_adr  = $random(seed);
         r_dat  = $random(seed);
         r_bsel = $random(seed);
         push_store(r_pc, r_adr, r_dat, r_bsel, 1'b0, acc);
         check_bit("store accepted", acc, 1'b1);
      end
      wait_drained(20);
      compare_transfers();
   endtask

   // First store stalls in ACCESS and seven more fill the 7-entry buffer
   task automatic test_full_stall();
      bit acc;
      hold_ready = 1'b1;
      push_store(32'h0000_3000, 32'h9000_0000, 32'h1111_0000, 4'hf, 1'b0, acc);
      @(negedge clk);
      while (!(psel && penable && empty)) @(negedge clk);
      for (int i = 0; i < 7; i++) begin
         check_bit("full_o", full, 1'b0);
         push_store(32'h0000_3004 + 4*i, 32'h9000_0004 + 4*i, 32'h2222_0000 + i, 4'h3,
                    1'b0, acc);
         check_bit("store accepted", acc, 1'b1);
         @(negedge clk);
      end
      check_bit("full_o", full, 1'b1);
      push_store(32'h0000_30ff, 32'hdead_0000, 32'hdead_beef, 4'hf, 1'b1, acc);
      check_bit("store accepted while full", acc, 1'b0);
      @(negedge clk);
      hold_ready = 1'b0;
      wait_drained(8);
      repeat (10) @(negedge clk);
      check_bit("empty_o", empty, 1'b1);
      compare_transfers();
   endtask

   // Slave error on the third of five stores
   task automatic test_slave_error();
      bit acc;
      check_count("err_o cycles before error test", err_pc_q.size(), 0);
      err_adr = 32'h0000_4008;
      err_en  = 1'b1;
      for (int i = 0; i < 5; i++) begin
         push_store(32'h0000_2000 + 4*i, 32'h0000_4000 + 4*i, 32'h5555_0000 + i, 4'hf,
                    1'b0, acc);
      end
      wait_drained(5);
      err_en = 1'b0;
      check_count("err_o cycles", err_pc_q.size(), 1);
      if (err_pc_q.size() > 0) begin
         check_word("err_pc_o", err_pc_q.pop_front(), 32'h0000_2008);
      end
      compare_transfers();
   endtask

   initial begin : main
      write = 1'b0;
      pc    = '0;
      adr   = '0;
      dat   = '0;
      bsel  = '0;
      @(negedge clk);
      while (rst) @(negedge clk);
      test_reset();
      test_single_store();
      test_random_stores();
      test_full_stall();
      test_slave_error();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin : watchdog
      drain_state_e st;
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      st = u_dut.u_drain.state_q;
      $display("Timeout after %0d cycles with the drain in state %s", cycles, st.name());
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule : tb_sb_top

`default_nettype wire

// ==== all.f ====
src/lsu_pkg.sv
src/sb_rd_if.sv
src/sb_dpram.sv
src/store_buffer.sv
src/sb_drain_apb.sv
src/sb_top.sv
testbench/tb_clock_gen.sv
testbench/tb_sb_top.sv
